// File: quad_pkg.sv
package quad_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Lane and word geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int num_lanes     = 8;
    localparam int pixel_width   = 16;
    localparam int weight_width  = 16;
    localparam int word_width    = num_lanes * pixel_width;
    localparam int product_width = 32;
    localparam int result_width  = 32;

    // One internal beat carries pixels plus weights, or the eight products
    localparam int beat_width      = 2 * word_width;
    localparam int beat_pixel_lsb  = 0;
    localparam int beat_weight_lsb = word_width;

    ////////////////////////////////////////////////////////////////////////////
    // Kernel and job sizing
    ////////////////////////////////////////////////////////////////////////////
    localparam int max_taps           = 16;
    localparam int tap_width          = 4;
    localparam int tap_count_width    = 5;
    localparam int window_count_width = 16;

    // Field positions inside job_parameters
    localparam int job_param_width = 32;
    localparam int job_taps_lsb    = 0;
    localparam int job_relu_bit    = 5;
    localparam int job_windows_lsb = 16;

    // Job FSM, one-hot
    localparam logic [3:0] st_idle     = 4'b0001;
    localparam logic [3:0] st_active   = 4'b0010;
    localparam logic [3:0] st_drain    = 4'b0100;
    localparam logic [3:0] st_complete = 4'b1000;

endpackage

// File: quad_if.sv
`timescale 1ns/1ps

// Job parameters seen by the pixel stage, stable for a whole job
interface job_cfg_if;
    import quad_pkg::*;

    logic                          active;
    logic [tap_count_width-1:0]    kernel_taps;
    logic                          relu_en;
    logic [window_count_width-1:0] num_windows;

    modport source (
        output active,
        output kernel_taps,
        output relu_en,
        output num_windows
    );

    modport sink (
        input  active,
        input  kernel_taps,
        input  relu_en,
        input  num_windows
    );

endinterface

// Valid/ready beat between pipeline stages
interface lane_beat_if;
    import quad_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [beat_width-1:0] lanes;
    // Beat closes a window
    logic                  last_tap;

    modport source (
        output valid,
        input  ready,
        output lanes,
        output last_tap
    );

    modport sink (
        input  valid,
        output ready,
        input  lanes,
        input  last_tap
    );

endinterface

// File: quad_job_ctrl.sv
`timescale 1ns/1ps

module quad_job_ctrl (
    input  logic                                clk_core,
    input  logic                                rst,
    input  logic                                job_start,
    input  logic [quad_pkg::job_param_width-1:0] job_parameters,
    output logic                                job_accept,
    output logic                                job_complete,
    input  logic                                job_complete_ack,
    input  logic                                result_fire,
    input  logic                                all_pixels_taken,
    output logic                                load_en,
    output logic                                table_clear,
    job_cfg_if.source                           cfg
);
    import quad_pkg::*;

    logic [3:0]                    state;
    logic [window_count_width-1:0] result_cnt;
    logic [window_count_width-1:0] result_cnt_next;
    logic [tap_count_width-1:0]    taps_field;

    assign taps_field      = job_parameters[job_taps_lsb +: tap_count_width];
    assign result_cnt_next = result_cnt + window_count_width'(result_fire);

    assign cfg.active   = (state == st_active);
    assign load_en      = (state == st_idle);
    assign job_complete = (state == st_complete);
    // Weight pointer restarts when the host acknowledges completion
    assign table_clear  = (state == st_complete) && job_complete_ack;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state           <= st_idle;
            job_accept      <= 1'b0;
            result_cnt      <= '0;
            cfg.kernel_taps <= tap_count_width'(max_taps);
            cfg.relu_en     <= 1'b0;
            cfg.num_windows <= '0;
        end else begin
            job_accept <= 1'b0;
            if (result_fire) begin
                result_cnt <= result_cnt_next;
            end
            case (state)
                st_idle: begin
                    if (job_start) begin
                        job_accept  <= 1'b1;
                        result_cnt  <= '0;
                        cfg.relu_en <= job_parameters[job_relu_bit];
                        cfg.num_windows <=
                            job_parameters[job_windows_lsb +: window_count_width];
                        // Zero or oversized tap counts run the full table
                        if (taps_field == '0 || taps_field > tap_count_width'(max_taps)) begin
                            cfg.kernel_taps <= tap_count_width'(max_taps);
                        end else begin
                            cfg.kernel_taps <= taps_field;
                        end
                        state <= st_active;
                    end
                end
                st_active: begin
                    if (all_pixels_taken) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    if (result_cnt_next == cfg.num_windows) begin
                        state <= st_complete;
                    end
                end
                st_complete: begin
                    if (job_complete_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: quad_weight_table.sv
`timescale 1ns/1ps

module quad_weight_table (
    input  logic                              clk_core,
    input  logic                              rst,
    input  logic                              weight_valid,
    output logic                              weight_ready,
    input  logic [quad_pkg::word_width-1:0]   weight_data,
    input  logic                              load_en,
    input  logic                              table_clear,
    input  logic [quad_pkg::tap_width-1:0]    rd_tap,
    output logic [quad_pkg::word_width-1:0]   rd_weights
);
    import quad_pkg::*;

    logic [word_width-1:0]      weight_mem [max_taps];
    // Counts 0..max_taps, saturates once the table is full
    logic [tap_count_width-1:0] wr_ptr;
    logic                       wr_fire;

    assign weight_ready = load_en && (wr_ptr < tap_count_width'(max_taps));
    assign wr_fire      = weight_valid && weight_ready;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (table_clear) begin
            wr_ptr <= '0;
        end else if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_fire) begin
            weight_mem[wr_ptr[tap_width-1:0]] <= weight_data;
        end
    end

    // Asynchronous read by tap index
    assign rd_weights = weight_mem[rd_tap];

endmodule

// File: quad_pixel_stage.sv
`timescale 1ns/1ps

module quad_pixel_stage (
    input  logic                              clk_core,
    input  logic                              rst,
    input  logic                              pixel_valid,
    output logic                              pixel_ready,
    input  logic [quad_pkg::word_width-1:0]   pixel_data,
    job_cfg_if.sink                           cfg,
    output logic [quad_pkg::tap_width-1:0]    rd_tap,
    input  logic [quad_pkg::word_width-1:0]   rd_weights,
    output logic                              all_pixels_taken,
    lane_beat_if.source                       beat_out
);
    import quad_pkg::*;

    logic [tap_width-1:0]          tap_cnt;
    logic [tap_count_width-1:0]    tap_limit;
    logic [window_count_width-1:0] win_cnt;
    logic                          tap_is_last;
    logic                          pixel_fire;
    logic [word_width-1:0]         relu_data;

    logic                          slot_valid;
    logic                          slot_last;
    logic [beat_width-1:0]         slot_lanes;

    ////////////////////////////////////////////////////////////////////////////
    // Intake control
    ////////////////////////////////////////////////////////////////////////////
    assign tap_limit        = cfg.kernel_taps - 1'b1;
    assign tap_is_last      = ({1'b0, tap_cnt} == tap_limit);
    assign all_pixels_taken = (win_cnt == cfg.num_windows);
    assign pixel_ready      = cfg.active && !all_pixels_taken &&
                              (!slot_valid || beat_out.ready);
    assign pixel_fire       = pixel_valid && pixel_ready;
    assign rd_tap           = tap_cnt;

    // ReLU per lane when enabled
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (cfg.relu_en && pixel_data[i*pixel_width + pixel_width - 1]) begin
                relu_data[i*pixel_width +: pixel_width] = '0;
            end else begin
                relu_data[i*pixel_width +: pixel_width] =
                    pixel_data[i*pixel_width +: pixel_width];
            end
        end
    end

    // Tap and window counters, held at zero between jobs
    always_ff @(posedge clk_core) begin
        if (rst || !cfg.active) begin
            tap_cnt <= '0;
            win_cnt <= '0;
        end else if (pixel_fire) begin
            if (tap_is_last) begin
                tap_cnt <= '0;
                win_cnt <= win_cnt + 1'b1;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // One-deep output slot
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else if (pixel_fire) begin
            slot_valid <= 1'b1;
        end else if (beat_out.ready) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_core) begin
        if (pixel_fire) begin
            slot_lanes[beat_pixel_lsb +: word_width]  <= relu_data;
            slot_lanes[beat_weight_lsb +: word_width] <= rd_weights;
            slot_last                                 <= tap_is_last;
        end
    end

    assign beat_out.valid    = slot_valid;
    assign beat_out.lanes    = slot_lanes;
    assign beat_out.last_tap = slot_last;

endmodule

// File: quad_mac_array.sv
`timescale 1ns/1ps

module quad_mac_array (
    input  logic        clk_core,
    input  logic        rst,
    lane_beat_if.sink   beat_in,
    lane_beat_if.source beat_out
);
    import quad_pkg::*;

    logic [beat_width-1:0] products;
    logic [beat_width-1:0] prod_reg;
    logic                  last_reg;
    logic                  out_valid;
    logic                  in_fire;

    // Stage advances when its register is empty or being drained
    assign beat_in.ready = !out_valid || beat_out.ready;
    assign in_fire       = beat_in.valid && beat_in.ready;

    // Eight signed 16x16 multipliers
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            products[i*product_width +: product_width] =
                $signed(beat_in.lanes[beat_pixel_lsb + i*pixel_width +: pixel_width]) *
                $signed(beat_in.lanes[beat_weight_lsb + i*weight_width +: weight_width]);
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (beat_in.ready) begin
            out_valid <= beat_in.valid;
        end
    end

    always_ff @(posedge clk_core) begin
        if (in_fire) begin
            prod_reg <= products;
            last_reg <= beat_in.last_tap;
        end
    end

    assign beat_out.valid    = out_valid;
    assign beat_out.lanes    = prod_reg;
    assign beat_out.last_tap = last_reg;

endmodule

// File: quad_window_accum.sv
`timescale 1ns/1ps

module quad_window_accum (
    input  logic                                clk_core,
    input  logic                                rst,
    lane_beat_if.sink                           beat_in,
    output logic                                result_valid,
    input  logic                                result_accept,
    output logic [quad_pkg::result_width-1:0]   result_data
);
    import quad_pkg::*;

    logic [result_width-1:0] lane_sum;
    logic [result_width-1:0] sum_reg;
    logic                    sum_valid;
    logic                    sum_last;
    logic                    sum_take;
    logic [result_width-1:0] acc;

    ////////////////////////////////////////////////////////////////////////////
    // Lane sum stage
    ////////////////////////////////////////////////////////////////////////////
    // Two's-complement wrap at 32 bits
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < num_lanes; i++) begin
            lane_sum = lane_sum + beat_in.lanes[i*product_width +: product_width];
        end
    end

    // Partial sums always move on, a window total waits for a free result slot
    assign sum_take      = sum_valid && (!sum_last || !result_valid || result_accept);
    assign beat_in.ready = !sum_valid || sum_take;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else if (beat_in.ready) begin
            sum_valid <= beat_in.valid;
        end
    end

    always_ff @(posedge clk_core) begin
        if (beat_in.valid && beat_in.ready) begin
            sum_reg  <= lane_sum;
            sum_last <= beat_in.last_tap;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window accumulator and result register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_accept) begin
                result_valid <= 1'b0;
            end
            if (sum_take) begin
                if (sum_last) begin
                    acc          <= '0;
                    result_valid <= 1'b1;
                end else begin
                    acc <= acc + sum_reg;
                end
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (sum_take && sum_last) begin
            result_data <= acc + sum_reg;
        end
    end

endmodule

// File: cnn_quad_top.sv
`timescale 1ns/1ps

module cnn_quad_top (
    input  logic                                  clk_core,
    input  logic                                  rst,
    input  logic                                  job_start,
    output logic                                  job_accept,
    input  logic [quad_pkg::job_param_width-1:0]  job_parameters,
    output logic                                  job_complete,
    input  logic                                  job_complete_ack,
    input  logic                                  pixel_valid,
    output logic                                  pixel_ready,
    input  logic [quad_pkg::word_width-1:0]       pixel_data,
    input  logic                                  weight_valid,
    output logic                                  weight_ready,
    input  logic [quad_pkg::word_width-1:0]       weight_data,
    output logic                                  result_valid,
    input  logic                                  result_accept,
    output logic [quad_pkg::result_width-1:0]     result_data
);
    import quad_pkg::*;

    logic                  result_fire;
    logic                  load_en;
    logic                  table_clear;
    logic                  all_pixels_taken;
    logic [tap_width-1:0]  rd_tap;
    logic [word_width-1:0] rd_weights;

    job_cfg_if   cfg ();
    lane_beat_if pix_beat ();
    lane_beat_if prod_beat ();

    assign result_fire = result_valid && result_accept;

    quad_job_ctrl u_job_ctrl (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_parameters   (job_parameters),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .result_fire      (result_fire),
        .all_pixels_taken (all_pixels_taken),
        .load_en          (load_en),
        .table_clear      (table_clear),
        .cfg              (cfg.source)
    );

    quad_weight_table u_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .load_en      (load_en),
        .table_clear  (table_clear),
        .rd_tap       (rd_tap),
        .rd_weights   (rd_weights)
    );

    quad_pixel_stage u_pixel_stage (
        .clk_core         (clk_core),
        .rst              (rst),
        .pixel_valid      (pixel_valid),
        .pixel_ready      (pixel_ready),
        .pixel_data       (pixel_data),
        .cfg              (cfg.sink),
        .rd_tap           (rd_tap),
        .rd_weights       (rd_weights),
        .all_pixels_taken (all_pixels_taken),
        .beat_out         (pix_beat.source)
    );

    quad_mac_array u_mac_array (
        .clk_core (clk_core),
        .rst      (rst),
        .beat_in  (pix_beat.sink),
        .beat_out (prod_beat.source)
    );

    quad_window_accum u_window_accum (
        .clk_core      (clk_core),
        .rst           (rst),
        .beat_in       (prod_beat.sink),
        .result_valid  (result_valid),
        .result_accept (result_accept),
        .result_data   (result_data)
    );

endmodule

// File: cnn_quad_sva.sv
`timescale 1ns/1ps

module cnn_quad_sva (
    input logic                              clk_core,
    input logic                              rst,
    input logic                              result_valid,
    input logic                              result_accept,
    input logic [quad_pkg::result_width-1:0] result_data,
    input logic                              job_complete,
    input logic                              job_complete_ack,
    input logic                              pixel_ready,
    input logic                              weight_ready
);

    int unsigned fail_count = 0;

    // Held result must not change
    result_stable: assert property (@(posedge clk_core) disable iff (rst)
        result_valid && !result_accept |=> $stable(result_data))
        else begin
            $error("result_data changed while waiting for result_accept");
            fail_count++;
        end

    complete_held: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            $error("job_complete dropped before job_complete_ack");
            fail_count++;
        end

    // Loading and streaming belong to different job phases
    ready_exclusive: assert property (@(posedge clk_core) disable iff (rst)
        !(pixel_ready && weight_ready))
        else begin
            $error("pixel_ready and weight_ready are both high");
            fail_count++;
        end

endmodule

bind cnn_quad_top cnn_quad_sva u_sva (.*);

// File: tb_cnn_quad.sv
`timescale 1ns/1ps

module tb_cnn_quad;
    import quad_pkg::*;

    localparam int wait_limit = 1000;

    logic                       clk_core;
    logic                       rst;
    logic                       job_start;
    logic                       job_accept;
    logic [job_param_width-1:0] job_parameters;
    logic                       job_complete;
    logic                       job_complete_ack;
    logic                       pixel_valid;
    logic                       pixel_ready;
    logic [word_width-1:0]      pixel_data;
    logic                       weight_valid;
    logic                       weight_ready;
    logic [word_width-1:0]      weight_data;
    logic                       result_valid;
    logic                       result_accept;
    logic [result_width-1:0]    result_data;

    int fd;
    int tag;
    int seed         = 32'h13a2e9f6;
    int errors       = 0;
    int checks       = 0;
    int results_seen = 0;
    int cur_windows  = 0;
    bit monitor_on   = 1'b0;
    bit in_job       = 1'b0;

    // Current job as read from the stimulus file
    logic [word_width-1:0]   weights [max_taps];
    logic [word_width-1:0]   pixels [256];
    logic [result_width-1:0] expected [64];

    cnn_quad_top uut (.*);

    initial begin
        clk_core = 1'b0;
        forever #50 clk_core = ~clk_core;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rule and reporting
    ////////////////////////////////////////////////////////////////////////////
    // Sum of pixel times tap weight over the window, 32-bit wrap
    function automatic logic [result_width-1:0] window_sum(int win, int taps, bit relu);
        logic signed [result_width-1:0] acc;
        logic signed [pixel_width-1:0]  pix;
        logic signed [weight_width-1:0] wgt;
        acc = '0;
        for (int t = 0; t < taps; t++) begin
            for (int i = 0; i < num_lanes; i++) begin
                pix = pixels[win*taps + t][i*pixel_width +: pixel_width];
                wgt = weights[t][i*weight_width +: weight_width];
                if (relu && pix < 0) begin
                    pix = '0;
                end
                acc = acc + pix * wgt;
            end
        end
        return acc;
    endfunction

    task automatic check_bit(string name, logic actual, logic exp);
        checks++;
        assert (actual === exp) else begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, actual);
        end
    endtask

    task automatic finish_run();
        errors = errors + uut.u_sva.fail_count;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checks, errors, uut.u_sva.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_fail(string what);
        errors++;
        $display("Timeout: no %s within %0d cycles", what, wait_limit);
        finish_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file reader
    ////////////////////////////////////////////////////////////////////////////
    // Next record letter, skipping blanks and comment lines
    task automatic next_tag(output int found);
        int c;
        found = -1;
        c = $fgetc(fd);
        while (c != -1 && found == -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                found = c;
            end
            if (found == -1) begin
                c = $fgetc(fd);
            end
        end
    endtask

    task automatic expect_tag(int want);
        int got;
        next_tag(got);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("Stimulus file: expected a %c record", want);
        end
    endtask

    task automatic read_word(output logic [word_width-1:0] value);
        int rc;
        rc = $fscanf(fd, "%h", value);
        checks++;
        assert (rc == 1) else begin
            errors++;
            $display("Stimulus file: a hex word could not be read");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus drivers
    ////////////////////////////////////////////////////////////////////////////
    task automatic send_weight(logic [word_width-1:0] data);
        int wait_cnt;
        weight_valid = 1'b1;
        weight_data  = data;
        wait_cnt     = 0;
        @(negedge clk_core);
        while (!weight_ready) begin
            wait_cnt++;
            if (wait_cnt > wait_limit) begin
                timeout_fail("weight_ready");
            end
            @(negedge clk_core);
        end
        @(posedge clk_core);
        #5;
        weight_valid = 1'b0;
    endtask

    task automatic send_pixel(logic [word_width-1:0] data);
        int wait_cnt;
        pixel_valid = 1'b1;
        pixel_data  = data;
        wait_cnt    = 0;
        @(negedge clk_core);
        while (!pixel_ready) begin
            wait_cnt++;
            if (wait_cnt > wait_limit) begin
                timeout_fail("pixel_ready");
            end
            @(negedge clk_core);
        end
        @(posedge clk_core);
        #5;
        pixel_valid = 1'b0;
    endtask

    task automatic start_job(logic [job_param_width-1:0] params);
        int wait_cnt;
        job_parameters = params;
        job_start      = 1'b1;
        @(posedge clk_core);
        #5;
        job_start = 1'b0;
        wait_cnt  = 0;
        @(negedge clk_core);
        while (!job_accept) begin
            wait_cnt++;
            if (wait_cnt > wait_limit) begin
                timeout_fail("job_accept");
            end
            @(negedge clk_core);
        end
        @(posedge clk_core);
        #5;
        in_job = 1'b1;
    endtask

    task automatic collect_results(int windows, bit backpressure);
        int          got;
        int          idle_cnt;
        logic [31:0] rnd;
        got      = 0;
        idle_cnt = 0;
        while (got < windows) begin
            rnd           = $random(seed);
            result_accept = backpressure ? rnd[0] : 1'b1;
            @(negedge clk_core);
            if (result_valid && result_accept) begin
                checks++;
                assert (result_data === expected[got]) else begin
                    errors++;
                    $display("ERR %0t result_data expected %h actual %h",
                             $time, expected[got], result_data);
                end
                got++;
                idle_cnt = 0;
            end else begin
                idle_cnt++;
                if (idle_cnt > wait_limit) begin
                    timeout_fail("result transfer");
                end
            end
            @(posedge clk_core);
            #5;
            results_seen = got;
        end
        result_accept = 1'b0;
    endtask

    task automatic finish_job();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk_core);
        while (!job_complete) begin
            wait_cnt++;
            if (wait_cnt > wait_limit) begin
                timeout_fail("job_complete");
            end
            @(negedge clk_core);
        end
        // Must hold without an acknowledge
        repeat (3) begin
            @(negedge clk_core);
            check_bit("job_complete", job_complete, 1'b1);
        end
        @(posedge clk_core);
        #5;
        job_complete_ack = 1'b1;
        in_job           = 1'b0;
        @(posedge clk_core);
        #5;
        job_complete_ack = 1'b0;
        @(negedge clk_core);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("weight_ready", weight_ready, 1'b1);
        @(posedge clk_core);
        #5;
    endtask

    task automatic run_job();
        logic [word_width-1:0]      word;
        logic [job_param_width-1:0] params;
        int                         backpressure;
        int                         taps;
        int                         windows;
        int                         rc;
        bit                         relu;
        read_word(word);
        params = word[job_param_width-1:0];
        rc     = $fscanf(fd, "%d", backpressure);
        checks++;
        assert (rc == 1) else begin
            errors++;
            $display("Stimulus file: a job has no back-pressure flag");
        end
        taps = params[job_taps_lsb +: tap_count_width];
        if (taps == 0 || taps > max_taps) begin
            taps = max_taps;
        end
        relu    = params[job_relu_bit];
        windows = params[job_windows_lsb +: window_count_width];
        for (int t = 0; t < taps; t++) begin
            expect_tag("W");
            read_word(weights[t]);
        end
        for (int p = 0; p < taps * windows; p++) begin
            expect_tag("P");
            read_word(pixels[p]);
        end
        for (int k = 0; k < windows; k++) begin
            expect_tag("R");
            read_word(word);
            expected[k] = window_sum(k, taps, relu);
            checks++;
            assert (word[result_width-1:0] == expected[k]) else begin
                errors++;
                $display("Stimulus file: window %0d lists %h but the rule gives %h",
                         k, word[result_width-1:0], expected[k]);
            end
        end
        for (int t = 0; t < taps; t++) begin
            send_weight(weights[t]);
        end
        results_seen = 0;
        cur_windows  = windows;
        start_job(params);
        fork
            begin
                for (int p = 0; p < taps * windows; p++) begin
                    send_pixel(pixels[p]);
                end
            end
            collect_results(windows, backpressure != 0);
        join
        finish_job();
    endtask

    // Ready signals against the job phase, completion against results
    always @(negedge clk_core) begin
        if (monitor_on) begin
            if (in_job) begin
                check_bit("weight_ready", weight_ready, 1'b0);
            end else if (!job_accept) begin
                check_bit("pixel_ready", pixel_ready, 1'b0);
            end
            if (job_complete) begin
                checks++;
                assert (results_seen == cur_windows) else begin
                    errors++;
                    $display("job_complete is high after %0d of %0d results",
                             results_seen, cur_windows);
                end
            end
        end
    end

    initial begin
        rst              = 1'b1;
        job_start        = 1'b0;
        job_parameters   = '0;
        job_complete_ack = 1'b0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        result_accept    = 1'b0;
        fd = $fopen("quad_stimulus.txt", "r");
        repeat (2) @(posedge clk_core);
        #5;
        rst = 1'b0;
        @(negedge clk_core);
        check_bit("job_accept", job_accept, 1'b0);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("pixel_ready", pixel_ready, 1'b0);
        check_bit("weight_ready", weight_ready, 1'b1);
        monitor_on = 1'b1;
        @(posedge clk_core);
        #5;
        if (fd == 0) begin
            errors++;
            $display("Could not open quad_stimulus.txt");
        end else begin
            next_tag(tag);
            while (tag != -1) begin
                checks++;
                assert (tag == "J") else begin
                    errors++;
                    $display("Stimulus file: a record stands outside a job");
                end
                if (tag == "J") begin
                    run_job();
                end
                next_tag(tag);
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule

// File: quad_stimulus.txt
# Records: J job_parameters(hex) back-pressure(0/1), then W weight words,
# P pixel words and R expected window sums, all hex with lane 7 leftmost
# Job 1: two taps, two windows, ReLU off
J 00020002 0
W 00010001000100010001000100010001
W 00020002000200020002000200020002
P 00080007000600050004000300020001
P ffffffffffffffffffffffffffffffff
P 01000100010001000100010001000100
P 00100010001000100010001000100010
R 00000014
R 00000900
# Job 2: three taps, two windows, ReLU on
J 00020023 0
W 00070006000500040003000200010000
W 00030003000300030003000300030003
W fffefffefffefffefffefffefffefffe
P 00020002000200020002000200020002
P fffb0005fffb0005fffb0005fffb0005
P 80008000800080008000800080008000
P 000a000a000a000a000a000a000a000a
P ffffffffffffffffffffffffffffffff
P 00080007000600050004000300020001
R 00000074
R 000000d0
# Job 3: two taps, three windows, ReLU off, random result back-pressure
J 00030002 1
W 7fff7fff7fff7fff7fff7fff7fff7fff
W ffffffffffffffffffffffffffffffff
P 7fff7fff7fff7fff7fff7fff7fff7fff
P 00000000000000000000000000000000
P 00010001000100010001000100010001
P 00010001000100010001000100010001
P ffffffffffffffffffffffffffffffff
P 80008000800080008000800080008000
R fff80008
R 0003fff0
R 00000008

// File: src.f
quad_pkg.sv
quad_if.sv
quad_job_ctrl.sv
quad_weight_table.sv
quad_pixel_stage.sv
quad_mac_array.sv
quad_window_accum.sv
cnn_quad_top.sv
cnn_quad_sva.sv
tb_cnn_quad.sv

// File: Bender.yml
package:
  name: cnn_quad

sources:
  - quad_pkg.sv
  - quad_if.sv
  - quad_job_ctrl.sv
  - quad_weight_table.sv
  - quad_pixel_stage.sv
  - quad_mac_array.sv
  - quad_window_accum.sv
  - cnn_quad_top.sv
  - target: test
    files:
      - cnn_quad_sva.sv
      - tb_cnn_quad.sv
